/* ks_consts.svh */
`ifndef KS_CONSTS_SVH
`define KS_CONSTS_SVH

// delay line storage, one word per sample slot
`define KS_DEPTH 1024

// legal loop lengths, the pitch is the tick rate divided by the length
`define KS_MIN_LENGTH 4
`define KS_MAX_LENGTH 1023

// active and pending length after reset
`define KS_DEFAULT_LENGTH 100

// noise generator start value, must not be zero or the LFSR locks up
`define KS_NOISE_SEED 16'hACE1

// feedback mask for the right-shifting Galois LFSR
`define KS_NOISE_TAPS 16'hB400

`endif

/* ks_cmd_pkg.sv */
package ks_cmd_pkg;

	// command opcodes as they arrive on cmd_op
	typedef enum logic [1:0]
	{
		OP_NOP        = 2'd0,
		OP_PLUCK      = 2'd1,
		OP_SET_LENGTH = 2'd2,
		OP_MUTE       = 2'd3
	} ks_op_t;

	// voice state, this decides what goes back into the delay line
	typedef enum logic [1:0]
	{
		ST_IDLE   = 2'd0, // silent, zeros are written back
		ST_EXCITE = 2'd1, // noise burst fills the loop
		ST_RING   = 2'd2  // averaged samples decay in the loop
	} voice_state_t;

endpackage

/* ks_sample_pkg.sv */
package ks_sample_pkg;

	// one audio sample in two's complement
	typedef logic signed [15:0] sample_t;

	// loop length and delay line address share this width
	typedef logic [9:0] len_t;

endpackage

/* ks_cmd_decode.sv */
`timescale 1ns/1ps

`include "ks_consts.svh"

module ks_cmd_decode (
	input  logic                       clk,
	input  logic                       trig_reset,
	input  logic                       cmd_valid,
	input  ks_cmd_pkg::ks_op_t         cmd_op,
	input  logic [15:0]                cmd_data,
	input  logic                       sample_tick,
	output ks_cmd_pkg::voice_state_t   voice_state,
	output ks_sample_pkg::len_t        loop_length,
	output logic                       restart
);
	import ks_cmd_pkg::*;
	import ks_sample_pkg::*;

	len_t pending_len; // takes effect at the next pluck
	len_t clamped_len;
	len_t excite_cnt;  // excitation ticks already taken
	logic last_excite;

	// requested length forced into the legal range
	always_comb
	begin
		if (cmd_data < `KS_MIN_LENGTH)
			clamped_len = len_t'(`KS_MIN_LENGTH);
		else if (cmd_data > `KS_MAX_LENGTH)
			clamped_len = len_t'(`KS_MAX_LENGTH);
		else
			clamped_len = cmd_data[9:0];
	end

	assign last_excite = (excite_cnt == loop_length - 10'd1); // burst is one loop long

	always_ff @(posedge clk)
	begin
		if (trig_reset)
		begin
			voice_state <= ST_IDLE;
			loop_length <= len_t'(`KS_DEFAULT_LENGTH);
			pending_len <= len_t'(`KS_DEFAULT_LENGTH);
			excite_cnt  <= '0;
			restart     <= 1'b0;
		end
		else
		begin
			restart <= 1'b0;

			// the tick sees the state before any command in this cycle
			if (sample_tick && voice_state == ST_EXCITE)
			begin
				if (last_excite)
					voice_state <= ST_RING;
				else
					excite_cnt <= excite_cnt + 10'd1;
			end

			// a command overrides whatever the tick did
			if (cmd_valid)
			begin
				case (cmd_op)
					OP_PLUCK:
					begin
						voice_state <= ST_EXCITE;
						loop_length <= pending_len; // pending length becomes active here
						excite_cnt  <= '0;
						restart     <= 1'b1;
					end
					OP_SET_LENGTH:
					begin
						pending_len <= clamped_len;
					end
					OP_MUTE:
					begin
						voice_state <= ST_IDLE;
					end
					default:
					begin
						// a nop leaves every register as it is
					end
				endcase
			end
		end
	end

endmodule

/* ks_noise_source.sv */
`timescale 1ns/1ps

`include "ks_consts.svh"

module ks_noise_source (
	input  logic                       clk,
	input  logic                       trig_reset,
	input  logic                       sample_tick,
	input  ks_cmd_pkg::voice_state_t   voice_state,
	output ks_sample_pkg::sample_t     noise
);
	import ks_cmd_pkg::*;

	logic [15:0] lfsr;
	logic [15:0] lfsr_next;
	logic        step;

	assign step = sample_tick && (voice_state == ST_EXCITE); // only excitation ticks use noise

	// shift right and fold the taps in when a one falls out
	assign lfsr_next = lfsr[0] ? ((lfsr >> 1) ^ `KS_NOISE_TAPS) : (lfsr >> 1);

	always_ff @(posedge clk)
	begin
		if (trig_reset)
			lfsr <= `KS_NOISE_SEED;
		else if (step)
			lfsr <= lfsr_next; // the sequence carries on across plucks
	end

	// the word handed out is the one from before the step
	always_ff @(posedge clk)
	begin
		if (step)
			noise <= $signed(lfsr);
	end

endmodule

/* ks_delay_line.sv */
`timescale 1ns/1ps

`include "ks_consts.svh"

module ks_delay_line (
	input  logic                     clk,
	input  logic                     trig_reset,
	input  logic                     sample_tick,
	input  logic                     restart,
	input  ks_sample_pkg::len_t      loop_length,
	input  ks_sample_pkg::sample_t   wr_data,
	input  logic                     wr_en,
	output ks_sample_pkg::sample_t   tap,
	output logic                     tap_valid
);
	import ks_sample_pkg::*;

	sample_t mem [0:`KS_DEPTH-1];
	len_t    ptr;      // one pointer serves the read and the later write
	len_t    ptr_next;
	logic    ptr_wrap;

	// wrap after the last slot of the active loop
	assign ptr_wrap = (ptr >= loop_length - 10'd1);
	assign ptr_next = ptr_wrap ? '0 : ptr + 10'd1;

	// read at the tick, write back two cycles later to the same slot
	always_ff @(posedge clk)
	begin
		if (sample_tick)
			tap <= mem[ptr];
		if (wr_en)
			mem[ptr] <= wr_data;
	end

	always_ff @(posedge clk)
	begin
		if (trig_reset)
		begin
			ptr       <= '0;
			tap_valid <= 1'b0;
		end
		else
		begin
			tap_valid <= sample_tick;

			if (restart)
				ptr <= '0; // a pluck starts the loop at slot 0
			else if (wr_en)
				ptr <= ptr_next; // advance only once the slot has been written
		end
	end

endmodule

/* ks_loop_filter.sv */
`timescale 1ns/1ps

module ks_loop_filter (
	input  logic                       clk,
	input  logic                       trig_reset,
	input  logic                       restart,
	input  ks_cmd_pkg::voice_state_t   voice_state,
	input  ks_sample_pkg::sample_t     noise,
	input  ks_sample_pkg::sample_t     tap,
	input  logic                       tap_valid,
	output ks_sample_pkg::sample_t     wr_data,
	output logic                       wr_en,
	output ks_sample_pkg::sample_t     sample_out,
	output logic                       sample_valid
);
	import ks_cmd_pkg::*;
	import ks_sample_pkg::*;

	voice_state_t       state_q;  // state as it was at the tick
	sample_t            prev_tap;
	logic signed [16:0] pair_sum; // one extra bit so the sum cannot overflow
	sample_t            average;
	sample_t            chosen;

	assign pair_sum = tap + prev_tap;
	assign average  = pair_sum[16:1]; // arithmetic halving of the signed sum

	always_comb
	begin
		case (state_q)
			ST_EXCITE: chosen = noise;
			ST_RING:   chosen = average;
			default:   chosen = '0; // idle writes silence
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (trig_reset)
		begin
			state_q      <= ST_IDLE;
			prev_tap     <= '0;
			sample_valid <= 1'b0;
		end
		else
		begin
			state_q      <= voice_state;
			sample_valid <= tap_valid;

			if (restart)
				prev_tap <= '0;
			else if (tap_valid)
				prev_tap <= tap;
		end
	end

	always_ff @(posedge clk)
	begin
		if (tap_valid)
			sample_out <= chosen;
	end

	// the output sample is exactly what goes back into the loop
	assign wr_data = sample_out;
	assign wr_en   = sample_valid;

endmodule

/* ks_voice_top.sv */
`timescale 1ns/1ps

module ks_voice_top (
	input  logic                       clk,
	input  logic                       trig_reset,
	input  logic                       cmd_valid,
	input  ks_cmd_pkg::ks_op_t         cmd_op,
	input  logic [15:0]                cmd_data,
	input  logic                       sample_tick,
	output ks_sample_pkg::sample_t     sample_out,
	output logic                       sample_valid,
	output ks_cmd_pkg::voice_state_t   voice_state
);
	import ks_sample_pkg::*;

	len_t    loop_length;
	logic    restart;
	sample_t noise;
	sample_t tap;
	logic    tap_valid;
	sample_t wr_data;
	logic    wr_en;

	ks_cmd_decode i_cmd_decode (
		.clk         (clk),
		.trig_reset  (trig_reset),
		.cmd_valid   (cmd_valid),
		.cmd_op      (cmd_op),
		.cmd_data    (cmd_data),
		.sample_tick (sample_tick),
		.voice_state (voice_state),
		.loop_length (loop_length),
		.restart     (restart)
	);

	ks_noise_source i_noise_source (
		.clk         (clk),
		.trig_reset  (trig_reset),
		.sample_tick (sample_tick),
		.voice_state (voice_state),
		.noise       (noise)
	);

	ks_delay_line i_delay_line (
		.clk         (clk),
		.trig_reset  (trig_reset),
		.sample_tick (sample_tick),
		.restart     (restart),
		.loop_length (loop_length),
		.wr_data     (wr_data),
		.wr_en       (wr_en),
		.tap         (tap),
		.tap_valid   (tap_valid)
	);

	ks_loop_filter i_loop_filter (
		.clk          (clk),
		.trig_reset   (trig_reset),
		.restart      (restart),
		.voice_state  (voice_state),
		.noise        (noise),
		.tap          (tap),
		.tap_valid    (tap_valid),
		.wr_data      (wr_data),
		.wr_en        (wr_en),
		.sample_out   (sample_out),
		.sample_valid (sample_valid)
	);

endmodule

/* tb_ks_checker.sv */
`timescale 1ns/1ps

`include "ks_consts.svh"

module tb_ks_checker (
	input  logic                       clk,
	input  logic                       trig_reset,
	input  logic                       cmd_valid,
	input  ks_cmd_pkg::ks_op_t         cmd_op,
	input  logic [15:0]                cmd_data,
	input  logic                       sample_tick,
	input  ks_sample_pkg::sample_t     sample_out,
	input  logic                       sample_valid,
	input  ks_cmd_pkg::voice_state_t   voice_state,
	input  logic                       len_check,
	input  logic [15:0]                exp_len,
	output int                         sample_errs,
	output int                         state_errs,
	output int                         length_errs
);
	import ks_cmd_pkg::*;
	import ks_sample_pkg::*;

	sample_t      model_mem [0:`KS_DEPTH-1];
	logic [15:0]  model_lfsr;
	voice_state_t model_state;
	len_t         model_len;
	len_t         model_pending;
	len_t         model_ptr;
	len_t         model_cnt;
	sample_t      model_prev;
	int           excite_seen; // DUT ticks in excitation since the last pluck
	logic         due_1;
	logic         due_2;       // a sample is owed at this edge
	sample_t      exp_1;
	sample_t      exp_2;

	function automatic len_t clamp_length(input logic [15:0] req);
		if (req < 16'(`KS_MIN_LENGTH))
			return len_t'(`KS_MIN_LENGTH);
		else if (req > 16'(`KS_MAX_LENGTH))
			return len_t'(`KS_MAX_LENGTH);
		return req[9:0];
	endfunction

	function automatic logic [15:0] next_noise(input logic [15:0] word);
		logic [15:0] shifted;
		shifted = word >> 1;
		if (word[0])
			shifted = shifted ^ `KS_NOISE_TAPS; // taps only when a one drops out
		return shifted;
	endfunction

	function automatic sample_t half_sum(input sample_t a, input sample_t b);
		int s;
		s = int'(a) + int'(b);
		return sample_t'(s >>> 1);
	endfunction

	task automatic model_reset();
		for (int i = 0; i < `KS_DEPTH; i++)
			model_mem[i] = '0;
		model_lfsr    = `KS_NOISE_SEED;
		model_state   = ST_IDLE;
		model_len     = len_t'(`KS_DEFAULT_LENGTH);
		model_pending = len_t'(`KS_DEFAULT_LENGTH);
		model_ptr     = '0;
		model_cnt     = '0;
		model_prev    = '0;
		excite_seen   = 0;
		due_1         = 1'b0;
		due_2         = 1'b0;
		exp_1         = '0;
		exp_2         = '0;
	endtask

	// one sample through the reference loop using the state from before the edge
	task automatic model_tick(output sample_t value);
		sample_t tap;
		tap = model_mem[model_ptr]; // read before the write back
		case (model_state)
			ST_EXCITE:
			begin
				value      = sample_t'(model_lfsr);
				model_lfsr = next_noise(model_lfsr);
			end
			ST_RING: value = half_sum(tap, model_prev);
			default: value = '0;
		endcase
		model_prev           = tap;
		model_mem[model_ptr] = value;
		if (model_ptr == model_len - 10'd1)
			model_ptr = '0;
		else
			model_ptr = model_ptr + 10'd1;
		if (model_state == ST_EXCITE)
		begin
			if (model_cnt == model_len - 10'd1)
				model_state = ST_RING; // burst has filled the whole loop
			else
				model_cnt = model_cnt + 10'd1;
		end
	endtask

	task automatic model_command(input ks_op_t op, input logic [15:0] data);
		case (op)
			OP_PLUCK:
			begin
				model_state = ST_EXCITE;
				model_len   = model_pending;
				model_cnt   = '0;
				model_ptr   = '0;
				model_prev  = '0;
				excite_seen = 0;
			end
			OP_SET_LENGTH: model_pending = clamp_length(data);
			OP_MUTE:       model_state = ST_IDLE;
			default:       ; // a nop changes nothing
		endcase
	endtask

	always @(posedge clk)
	begin
		if (trig_reset)
		begin
			model_reset();
			sample_errs = 0;
			state_errs  = 0;
			length_errs = 0;
		end
		else
		begin
			if (voice_state !== model_state)
			begin
				state_errs++;
				$display("FAIL t=%0t voice_state expected %0d got %0d", $time, model_state,
					voice_state);
			end
			if (sample_valid !== due_2)
			begin
				sample_errs++;
				$display("FAIL t=%0t sample_valid expected %0b got %0b", $time, due_2,
					sample_valid);
			end
			else if (due_2 && sample_out !== exp_2)
			begin
				sample_errs++;
				$display("FAIL t=%0t sample_out expected %0d got %0d", $time, exp_2, sample_out);
			end
			due_2 = due_1;
			exp_2 = exp_1;
			due_1 = 1'b0;
			if (sample_tick)
			begin
				if (voice_state == ST_EXCITE)
					excite_seen++;
				model_tick(exp_1);
				due_1 = 1'b1; // output due two edges later
			end
			if (cmd_valid)
				model_command(cmd_op, cmd_data);
			if (len_check && exp_len != 16'd0)
			begin
				if (excite_seen != int'(exp_len))
				begin
					length_errs++;
					$display("FAIL t=%0t excite_ticks expected %0d got %0d", $time, exp_len,
						excite_seen);
				end
				if (model_len != exp_len[9:0])
				begin
					length_errs++;
					$display("reference length %0d disagrees with the input file length %0d",
						model_len, exp_len);
				end
			end
		end
	end

endmodule

/* tb_ks_voice.sv */
`timescale 1ns/1ps

module tb_ks_voice;
	import ks_cmd_pkg::*;
	import ks_sample_pkg::*;

	localparam int VALID_TIMEOUT = 8; // cycles allowed from a tick to sample_valid

	logic         clk;
	logic         trig_reset;
	logic         cmd_valid;
	ks_op_t       cmd_op;
	logic [15:0]  cmd_data;
	logic         sample_tick;
	sample_t      sample_out;
	logic         sample_valid;
	voice_state_t voice_state;
	logic         len_check;
	logic [15:0]  exp_len;
	int           sample_errs;
	int           state_errs;
	int           length_errs;
	int           timeout_errs;
	int           file_errs;
	int           fd;
	int           lines_run;
	int           fields;
	int           op;
	int           data;
	int           ticks;
	int           len;
	string        line;

	ks_voice_top i_dut (
		.clk          (clk),
		.trig_reset   (trig_reset),
		.cmd_valid    (cmd_valid),
		.cmd_op       (cmd_op),
		.cmd_data     (cmd_data),
		.sample_tick  (sample_tick),
		.sample_out   (sample_out),
		.sample_valid (sample_valid),
		.voice_state  (voice_state)
	);

	tb_ks_checker i_checker (
		.clk          (clk),
		.trig_reset   (trig_reset),
		.cmd_valid    (cmd_valid),
		.cmd_op       (cmd_op),
		.cmd_data     (cmd_data),
		.sample_tick  (sample_tick),
		.sample_out   (sample_out),
		.sample_valid (sample_valid),
		.voice_state  (voice_state),
		.len_check    (len_check),
		.exp_len      (exp_len),
		.sample_errs  (sample_errs),
		.state_errs   (state_errs),
		.length_errs  (length_errs)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic send_command(input ks_op_t op_code, input logic [15:0] value);
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd_op    <= op_code;
		cmd_data  <= value;
		@(posedge clk);
		cmd_valid <= 1'b0;
		cmd_op    <= OP_NOP;
		repeat (3) @(posedge clk); // restart settles before the next tick
	endtask

	task automatic run_ticks(input int count);
		int   waited;
		logic seen;
		for (int i = 0; i < count; i++)
		begin
			@(posedge clk);
			sample_tick <= 1'b1;
			@(posedge clk);
			sample_tick <= 1'b0;
			waited = 0;
			seen   = 1'b0;
			while (!seen && waited < VALID_TIMEOUT)
			begin
				@(posedge clk);
				waited++;
				seen = sample_valid;
			end
			if (!seen)
			begin
				timeout_errs++;
				$display("no sample_valid within %0d cycles of the tick before %0t",
					VALID_TIMEOUT, $time);
			end
		end
	endtask

	task automatic check_length(input logic [15:0] expected);
		@(posedge clk);
		len_check <= 1'b1;
		exp_len   <= expected;
		@(posedge clk);
		len_check <= 1'b0;
	endtask

	initial
	begin
		trig_reset   = 1'b1;
		cmd_valid    = 1'b0;
		cmd_op       = OP_NOP;
		cmd_data     = '0;
		sample_tick  = 1'b0;
		len_check    = 1'b0;
		exp_len      = '0;
		timeout_errs = 0;
		file_errs    = 0;
		lines_run    = 0;
		repeat (10) @(posedge clk);
		trig_reset <= 1'b0;
		repeat (2) @(posedge clk);

		fd = $fopen("ks_input.txt", "r");
		if (fd == 0)
		begin
			file_errs++;
			$display("could not open ks_input.txt");
		end
		else
		begin
			while (!$feof(fd))
			begin
				line   = "";
				fields = 0;
				if ($fgets(line, fd) > 0)
					fields = $sscanf(line, "%d %d %d %d", op, data, ticks, len);
				if (fields == 4) // comment and blank lines do not parse
				begin
					send_command(ks_op_t'(op[1:0]), data[15:0]);
					run_ticks(ticks);
					check_length(len[15:0]);
					lines_run++;
				end
			end
			$fclose(fd);
			if (lines_run == 0)
			begin
				file_errs++;
				$display("no command lines found in ks_input.txt");
			end
		end

		repeat (4) @(posedge clk);
		$display("errors: sample %0d, state %0d, length %0d, timeout %0d, file %0d",
			sample_errs, state_errs, length_errs, timeout_errs, file_errs);
		if (sample_errs + state_errs + length_errs + timeout_errs + file_errs == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* ks_input.txt */
# columns: opcode data ticks expected_length (decimal)
# opcode 0 nop, 1 pluck, 2 set length, 3 mute; expected_length 0 skips the length check
0 0 20 0
1 0 130 100
0 0 120 0
3 0 12 0
2 2 0 0
1 0 40 4
2 500 0 0
1 0 560 500
3 0 20 0
1 0 520 500
2 2000 0 0
1 0 1100 1023
3 0 10 0
0 0 8 0

/* ks_voice.f */
+incdir+.
ks_cmd_pkg.sv
ks_sample_pkg.sv
ks_cmd_decode.sv
ks_noise_source.sv
ks_delay_line.sv
ks_loop_filter.sv
ks_voice_top.sv
tb_ks_checker.sv
tb_ks_voice.sv

/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f ks_voice.f --top-module tb_ks_voice \
	&& ./obj_dir/Vtb_ks_voice > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && { echo "simulation FAILED"; exit 1; } || echo "simulation passed"
